// File: source/core_pkg.sv
package core_pkg;

    // Number of stage registers between ID and WB, inclusive
    localparam int NUM_STAGES_TRACKED = 4;

    typedef logic [4:0] reg_addr_t;

    // Operand source for an ID stage register read
    typedef enum logic [2:0] {
        NO_FORWARD,
        FWD_EX_TO_ID,
        FWD_MEM_ALU_RES_TO_ID,
        FWD_MEM_RDATA_TO_ID,
        FWD_WB_ALU_RES_TO_ID,
        FWD_WB_RDATA_TO_ID
    } forward_t;

    // Next PC selection
    typedef enum logic [1:0] {
        PC_PLUS4,
        PC_BRANCH,
        PC_JAL,
        PC_JALR
    } pc_source_t;

    // Decoded control fields, carried from ID to WB
    typedef struct packed {
        logic       valid;
        reg_addr_t  rs1_addr;
        reg_addr_t  rs2_addr;
        reg_addr_t  rd_addr;
        // ALU, LUI/AUIPC or link result
        logic       alu_wen;
        // Load data
        logic       mem_wen;
        pc_source_t pc_source;
        logic       is_branch;
    } ctrl_t;

endpackage

// File: source/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import core_pkg::*; (
    input  logic [31:0] instr_i,
    input  logic        valid_i,
    output ctrl_t       ctrl_o
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic [6:0] opcode;
    reg_addr_t  rd_field;
    reg_addr_t  rs1_field;
    reg_addr_t  rs2_field;

    assign opcode    = instr_i[6:0];
    assign rd_field  = instr_i[11:7];
    assign rs1_field = instr_i[19:15];
    assign rs2_field = instr_i[24:20];

    always_comb begin
        ctrl_o = '0;
        ctrl_o.pc_source = PC_PLUS4;
        if (valid_i) begin
            case (opcode)
                // R-type, both sources
                OPC_OP: begin
                    ctrl_o.valid    = 1'b1;
                    ctrl_o.rs1_addr = rs1_field;
                    ctrl_o.rs2_addr = rs2_field;
                    ctrl_o.rd_addr  = rd_field;
                    ctrl_o.alu_wen  = 1'b1;
                end
                OPC_OP_IMM: begin
                    ctrl_o.valid    = 1'b1;
                    ctrl_o.rs1_addr = rs1_field;
                    ctrl_o.rd_addr  = rd_field;
                    ctrl_o.alu_wen  = 1'b1;
                end
                OPC_LOAD: begin
                    ctrl_o.valid    = 1'b1;
                    ctrl_o.rs1_addr = rs1_field;
                    ctrl_o.rd_addr  = rd_field;
                    ctrl_o.mem_wen  = 1'b1;
                end
                // No destination for store or branch
                OPC_STORE: begin
                    ctrl_o.valid    = 1'b1;
                    ctrl_o.rs1_addr = rs1_field;
                    ctrl_o.rs2_addr = rs2_field;
                end
                OPC_BRANCH: begin
                    ctrl_o.valid     = 1'b1;
                    ctrl_o.rs1_addr  = rs1_field;
                    ctrl_o.rs2_addr  = rs2_field;
                    ctrl_o.pc_source = PC_BRANCH;
                    ctrl_o.is_branch = 1'b1;
                end
                OPC_JAL: begin
                    ctrl_o.valid     = 1'b1;
                    ctrl_o.rd_addr   = rd_field;
                    ctrl_o.alu_wen   = 1'b1;
                    ctrl_o.pc_source = PC_JAL;
                end
                OPC_JALR: begin
                    ctrl_o.valid     = 1'b1;
                    ctrl_o.rs1_addr  = rs1_field;
                    ctrl_o.rd_addr   = rd_field;
                    ctrl_o.alu_wen   = 1'b1;
                    ctrl_o.pc_source = PC_JALR;
                end
                OPC_LUI, OPC_AUIPC: begin
                    ctrl_o.valid   = 1'b1;
                    ctrl_o.rd_addr = rd_field;
                    ctrl_o.alu_wen = 1'b1;
                end
                // Unknown opcode stays a bubble
                default: begin
                    ctrl_o = '0;
                end
            endcase
        end
    end

endmodule

// File: source/stage_tracker.sv
`timescale 1ns/1ps

module stage_tracker import core_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,

    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic        branch_taken_i,

    input  logic        stall_if_i,
    input  logic        stall_id_i,
    input  logic        flush_id_i,
    input  logic        flush_ex_i,

    input  ctrl_t       id_ctrl_i,

    output logic [31:0] id_instr_o,
    output logic        id_valid_o,
    output ctrl_t       ex_ctrl_o,
    output ctrl_t       mem_ctrl_o,
    output ctrl_t       wb_ctrl_o,

    output logic        branch_decision_ex_o
);

    logic accept;
    logic ex_bubble;

    // Handshake: ready is the inverse of the IF stall
    assign accept = instr_valid_i && !stall_if_i;

    // Flush overrides the load-use bubble
    assign ex_bubble = flush_ex_i || (stall_id_i && !flush_id_i);

    assign branch_decision_ex_o = branch_taken_i && ex_ctrl_o.valid && ex_ctrl_o.is_branch;

    // IF to ID valid flag
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            id_valid_o <= 1'b0;
        end else if (flush_id_i) begin
            id_valid_o <= 1'b0;
        end else if (!stall_id_i) begin
            id_valid_o <= accept;
        end
    end

    // Raw word, only meaningful with id_valid_o
    always_ff @(posedge clk_i) begin
        if (!stall_id_i && accept) begin
            id_instr_o <= instr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ex_ctrl_o  <= '0;
            mem_ctrl_o <= '0;
            wb_ctrl_o  <= '0;
        end else begin
            if (ex_bubble) begin
                ex_ctrl_o <= '0;
            end else begin
                ex_ctrl_o <= id_ctrl_i;
            end
            // MEM and WB never stall
            mem_ctrl_o <= ex_ctrl_o;
            wb_ctrl_o  <= mem_ctrl_o;
        end
    end

    // EX flush only for a taken branch actually sitting in EX
    a_flush_ex_branch: assert property (
        @(posedge clk_i) disable iff (reset_i)
        flush_ex_i |-> (ex_ctrl_o.valid && ex_ctrl_o.is_branch && branch_taken_i)
    );

    // The squashed slot drains to WB as a bubble
    a_flush_ex_drains: assert property (
        @(posedge clk_i) disable iff (reset_i)
        flush_ex_i |-> ##(NUM_STAGES_TRACKED - 1)
            (!wb_ctrl_o.valid && !wb_ctrl_o.alu_wen && !wb_ctrl_o.mem_wen)
    );

endmodule

// File: source/controller.sv
`timescale 1ns/1ps

module controller import core_pkg::*; (
    // Forwarding selects
    output forward_t   fwd_op1_o,
    output forward_t   fwd_op2_o,

    // Register addresses per stage
    input  reg_addr_t  rs1_addr_id_i,
    input  reg_addr_t  rs2_addr_id_i,
    input  reg_addr_t  rd_addr_ex_i,
    input  reg_addr_t  rd_addr_mem_i,
    input  reg_addr_t  rd_addr_wb_i,

    input  logic       reg_alu_wen_ex_i,
    input  logic       reg_alu_wen_mem_i,
    input  logic       reg_alu_wen_wb_i,
    input  logic       reg_mem_wen_mem_i,
    input  logic       reg_mem_wen_wb_i,

    // Stalls
    output logic       stall_if_o,
    output logic       stall_id_o,
    output logic       stall_ex_o,
    output logic       stall_mem_o,

    input  logic       reg_mem_wen_ex_i,

    // Flushes
    output logic       flush_id_o,
    output logic       flush_ex_o,
    output logic       flush_mem_o,
    output logic       flush_wb_o,

    input  pc_source_t pc_source_id_i,
    input  logic       branch_decision_ex_i
);

    logic load_use_rs1;
    logic load_use_rs2;
    logic jump_in_id;

    // Youngest writer first; x0 never forwarded
    function automatic forward_t select_source(input reg_addr_t rs);
        forward_t sel;
        sel = NO_FORWARD;
        if (rs != '0) begin
            if (rd_addr_ex_i == rs && reg_alu_wen_ex_i) begin
                sel = FWD_EX_TO_ID;
            end else if (rd_addr_mem_i == rs && reg_alu_wen_mem_i) begin
                sel = FWD_MEM_ALU_RES_TO_ID;
            end else if (rd_addr_mem_i == rs && reg_mem_wen_mem_i) begin
                sel = FWD_MEM_RDATA_TO_ID;
            end else if (rd_addr_wb_i == rs && reg_alu_wen_wb_i) begin
                sel = FWD_WB_ALU_RES_TO_ID;
            end else if (rd_addr_wb_i == rs && reg_mem_wen_wb_i) begin
                sel = FWD_WB_RDATA_TO_ID;
            end
        end
        return sel;
    endfunction

    assign fwd_op1_o = select_source(rs1_addr_id_i);
    assign fwd_op2_o = select_source(rs2_addr_id_i);

    // Load data not ready until MEM
    assign load_use_rs1 = (rs1_addr_id_i != '0) && (rd_addr_ex_i == rs1_addr_id_i);
    assign load_use_rs2 = (rs2_addr_id_i != '0) && (rd_addr_ex_i == rs2_addr_id_i);

    assign stall_id_o  = reg_mem_wen_ex_i && (load_use_rs1 || load_use_rs2);
    assign stall_if_o  = stall_id_o;
    assign stall_ex_o  = 1'b0;
    assign stall_mem_o = 1'b0;

    assign jump_in_id = (pc_source_id_i == PC_JAL) || (pc_source_id_i == PC_JALR);

    assign flush_id_o  = jump_in_id || branch_decision_ex_i;
    assign flush_ex_o  = branch_decision_ex_i;
    assign flush_mem_o = 1'b0;
    assign flush_wb_o  = 1'b0;

endmodule

// File: source/hazard_top.sv
`timescale 1ns/1ps

module hazard_top import core_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,

    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    output logic        instr_ready_o,

    input  logic        branch_taken_i,

    output forward_t    fwd_op1_o,
    output forward_t    fwd_op2_o,
    output logic        stall_o,
    output logic        flush_id_o,
    output logic        flush_ex_o
);

    logic [31:0] id_instr;
    logic        id_valid;
    ctrl_t       id_ctrl;
    ctrl_t       ex_ctrl;
    ctrl_t       mem_ctrl;
    ctrl_t       wb_ctrl;
    logic        branch_decision_ex;
    logic        stall_if;
    logic        stall_id;

    assign instr_ready_o = !stall_if;
    assign stall_o       = stall_id;

    instr_decode instr_decode_inst (
        .instr_i (id_instr),
        .valid_i (id_valid),
        .ctrl_o  (id_ctrl)
    );

    stage_tracker stage_tracker_inst (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .instr_valid_i        (instr_valid_i),
        .instr_i              (instr_i),
        .branch_taken_i       (branch_taken_i),
        .stall_if_i           (stall_if),
        .stall_id_i           (stall_id),
        .flush_id_i           (flush_id_o),
        .flush_ex_i           (flush_ex_o),
        .id_ctrl_i            (id_ctrl),
        .id_instr_o           (id_instr),
        .id_valid_o           (id_valid),
        .ex_ctrl_o            (ex_ctrl),
        .mem_ctrl_o           (mem_ctrl),
        .wb_ctrl_o            (wb_ctrl),
        .branch_decision_ex_o (branch_decision_ex)
    );

    controller controller_inst (
        .fwd_op1_o            (fwd_op1_o),
        .fwd_op2_o            (fwd_op2_o),
        .rs1_addr_id_i        (id_ctrl.rs1_addr),
        .rs2_addr_id_i        (id_ctrl.rs2_addr),
        .rd_addr_ex_i         (ex_ctrl.rd_addr),
        .rd_addr_mem_i        (mem_ctrl.rd_addr),
        .rd_addr_wb_i         (wb_ctrl.rd_addr),
        .reg_alu_wen_ex_i     (ex_ctrl.alu_wen),
        .reg_alu_wen_mem_i    (mem_ctrl.alu_wen),
        .reg_alu_wen_wb_i     (wb_ctrl.alu_wen),
        .reg_mem_wen_mem_i    (mem_ctrl.mem_wen),
        .reg_mem_wen_wb_i     (wb_ctrl.mem_wen),
        .stall_if_o           (stall_if),
        .stall_id_o           (stall_id),
        .stall_ex_o           (),
        .stall_mem_o          (),
        .reg_mem_wen_ex_i     (ex_ctrl.mem_wen),
        .flush_id_o           (flush_id_o),
        .flush_ex_o           (flush_ex_o),
        .flush_mem_o          (),
        .flush_wb_o           (),
        .pc_source_id_i       (id_ctrl.pc_source),
        .branch_decision_ex_i (branch_decision_ex)
    );

endmodule

// File: include/hazard_vectors.svh
`ifndef HAZARD_VECTORS_SVH
`define HAZARD_VECTORS_SVH

// One row per clock cycle after reset
// Expected values hold in the cycle the row is driven
// Columns are word, valid, branch_taken, fwd_op1, fwd_op2, {stall, flush_id, flush_ex, ready}

task automatic load_vectors();
    // Reset state, then ALU results forwarded from EX, MEM and WB
    push_row(add_word(1, 2, 3), 1'b1, 1'b0, F_NO, F_NO, 4'b0001);
    push_row(add_word(4, 1, 1), 1'b1, 1'b0, F_NO, F_NO, 4'b0001);
    push_row(add_word(5, 0, 1), 1'b1, 1'b0, F_EX, F_EX, 4'b0001);
    push_row(add_word(6, 1, 4), 1'b1, 1'b0, F_NO, F_MA, 4'b0001);
    push_row(add_word(7, 5, 6), 1'b1, 1'b0, F_WA, F_MA, 4'b0001);
    // Youngest of several x7 writers wins
    push_row(addi_word(7, 7), 1'b1, 1'b0, F_MA, F_EX, 4'b0001);
    push_row(add_word(8, 7, 7), 1'b1, 1'b0, F_EX, F_NO, 4'b0001);
    push_row(add_word(9, 7, 6), 1'b1, 1'b0, F_EX, F_EX, 4'b0001);
    push_row(add_word(0, 1, 7), 1'b1, 1'b0, F_MA, F_NO, 4'b0001);
    // x0 as source and as destination
    push_row(add_word(10, 0, 0), 1'b1, 1'b0, F_NO, F_WA, 4'b0001);
    push_row(lui_word(0), 1'b1, 1'b0, F_NO, F_NO, 4'b0001);
    push_row(add_word(11, 0, 10), 1'b1, 1'b0, F_NO, F_NO, 4'b0001);
    push_row(lw_word(12, 0), 1'b1, 1'b0, F_NO, F_MA, 4'b0001);
    // Load-use stall, then load data from MEM and from WB
    push_row(add_word(13, 12, 1), 1'b1, 1'b0, F_NO, F_NO, 4'b0001);
    push_row(add_word(14, 0, 12), 1'b1, 1'b0, F_NO, F_NO, 4'b1000);
    push_row(add_word(14, 0, 12), 1'b1, 1'b0, F_MR, F_NO, 4'b0001);
    push_row(lw_word(15, 1), 1'b1, 1'b0, F_NO, F_WR, 4'b0001);
    push_row(add_word(16, 2, 3), 1'b1, 1'b0, F_NO, F_NO, 4'b0001);
    push_row(add_word(17, 15, 2), 1'b1, 1'b0, F_NO, F_NO, 4'b0001);
    push_row(add_word(18, 2, 15), 1'b1, 1'b0, F_MR, F_NO, 4'b0001);
    // Jumps in ID drop the word behind them
    push_row(jal_word(20), 1'b1, 1'b0, F_NO, F_WR, 4'b0001);
    push_row(add_word(22, 0, 0), 1'b1, 1'b0, F_NO, F_NO, 4'b0101);
    push_row(add_word(23, 22, 20), 1'b1, 1'b0, F_NO, F_NO, 4'b0001);
    push_row(jalr_word(24, 23), 1'b1, 1'b0, F_NO, F_MA, 4'b0001);
    push_row(add_word(25, 0, 0), 1'b1, 1'b0, F_EX, F_NO, 4'b0101);
    push_row(add_word(26, 25, 24), 1'b1, 1'b0, F_NO, F_NO, 4'b0001);
    // Taken branch in EX squashes ID and EX
    push_row(beq_word(26, 1), 1'b1, 1'b0, F_NO, F_MA, 4'b0001);
    push_row(add_word(27, 0, 0), 1'b1, 1'b0, F_EX, F_NO, 4'b0001);
    push_row(add_word(28, 0, 0), 1'b1, 1'b1, F_NO, F_NO, 4'b0111);
    push_row(add_word(29, 27, 28), 1'b1, 1'b0, F_NO, F_NO, 4'b0001);
    push_row(add_word(30, 1, 2), 1'b1, 1'b0, F_NO, F_NO, 4'b0001);
    // Taken flag while a plain add sits in EX
    push_row(add_word(31, 30, 29), 1'b1, 1'b1, F_NO, F_NO, 4'b0001);
    push_row(32'h0, 1'b0, 1'b0, F_EX, F_MA, 4'b0001);
    push_row(32'h0, 1'b0, 1'b0, F_NO, F_NO, 4'b0001);
endtask

`endif

// File: testbench/hazard_tb.sv
`timescale 1ns/1ps

module hazard_tb import core_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;

    localparam forward_t F_NO = NO_FORWARD;
    localparam forward_t F_EX = FWD_EX_TO_ID;
    localparam forward_t F_MA = FWD_MEM_ALU_RES_TO_ID;
    localparam forward_t F_MR = FWD_MEM_RDATA_TO_ID;
    localparam forward_t F_WA = FWD_WB_ALU_RES_TO_ID;
    localparam forward_t F_WR = FWD_WB_RDATA_TO_ID;

    typedef struct packed {
        logic [31:0] instr;
        logic        valid;
        logic        taken;
        forward_t    fwd_op1;
        forward_t    fwd_op2;
        logic        stall;
        logic        flush_id;
        logic        flush_ex;
        logic        ready;
    } row_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_ready;
    logic        branch_taken;
    forward_t    fwd_op1;
    forward_t    fwd_op2;
    logic        stall;
    logic        flush_id;
    logic        flush_ex;

    row_t vectors[$];
    logic vectors_ready = 1'b0;
    int   row_errors;
    int   passed;
    int   failed;

    hazard_top hazard_top_inst (
        .clk_i          (clk),
        .reset_i        (reset),
        .instr_valid_i  (instr_valid),
        .instr_i        (instr),
        .instr_ready_o  (instr_ready),
        .branch_taken_i (branch_taken),
        .fwd_op1_o      (fwd_op1),
        .fwd_op2_o      (fwd_op2),
        .stall_o        (stall),
        .flush_id_o     (flush_id),
        .flush_ex_o     (flush_ex)
    );

    always begin
        #(CLK_PERIOD / 2);
        clk = ~clk;
    end

    // RV32I encodings, immediates are arbitrary
    function automatic logic [31:0] add_word(input int rd, input int rs1, input int rs2);
        return {7'b0000000, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input int rd, input int rs1);
        return {12'h001, 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] lw_word(input int rd, input int rs1);
        return {12'h000, 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic logic [31:0] beq_word(input int rs1, input int rs2);
        return {7'b0000000, 5'(rs2), 5'(rs1), 3'b000, 5'b00000, 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input int rd);
        return {20'h00100, 5'(rd), 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr_word(input int rd, input int rs1);
        return {12'h000, 5'(rs1), 3'b000, 5'(rd), 7'b1100111};
    endfunction

    function automatic logic [31:0] lui_word(input int rd);
        return {20'h12345, 5'(rd), 7'b0110111};
    endfunction

    // Flags are {stall, flush_id, flush_ex, ready}
    task automatic push_row(input logic [31:0] word, input logic valid, input logic taken,
                            input forward_t f1, input forward_t f2, input logic [3:0] flags);
        row_t row;
        row = {word, valid, taken, f1, f2, flags};
        vectors.push_back(row);
    endtask

    `include "hazard_vectors.svh"

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            row_errors++;
        end
    endtask

    initial begin
        row_t row;
        logic hold;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        branch_taken = 1'b0;
        hold = 1'b0;
        passed = 0;
        failed = 0;
        load_vectors();
        vectors_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < vectors.size(); i++) begin
            row = vectors[i];
            // A word not taken stays on the bus
            if (!hold) begin
                instr_valid <= row.valid;
                instr <= row.instr;
            end
            branch_taken <= row.taken;
            @(negedge clk);
            row_errors = 0;
            check_field("fwd_op1_o", 32'(row.fwd_op1), 32'(fwd_op1));
            check_field("fwd_op2_o", 32'(row.fwd_op2), 32'(fwd_op2));
            check_field("stall_o", 32'(row.stall), 32'(stall));
            check_field("flush_id_o", 32'(row.flush_id), 32'(flush_id));
            check_field("flush_ex_o", 32'(row.flush_ex), 32'(flush_ex));
            check_field("instr_ready_o", 32'(row.ready), 32'(instr_ready));
            if (row_errors == 0) begin
                passed++;
                $display("row %0d ok", i);
            end else begin
                failed++;
                $display("row %0d had %0d mismatches", i, row_errors);
            end
            hold = instr_valid && !instr_ready;
            @(posedge clk);
        end

        $display("%0d tests, %0d passed, %0d failed", passed + failed, passed, failed);
        if (failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Three cycles per row is far more than the table needs
    initial begin
        int timeout_ns;
        wait (vectors_ready);
        timeout_ns = vectors.size() * 3 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
        #(timeout_ns);
        $display("Timeout: the stimulus table did not finish within %0d ns", timeout_ns);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: build.f
+incdir+include
source/core_pkg.sv
source/instr_decode.sv
source/stage_tracker.sv
source/controller.sv
source/hazard_top.sv
testbench/hazard_tb.sv
